// ==== project.f ====
+incdir+.
uart_tx_pkg.sv
uart_tx_fsm.sv
uart_tx_shifter.sv
uart_tx_bit_counter.sv
uart_tx_line_driver.sv
uart_tx_top.sv
tb_uart_tx.sv

// ==== tb_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_tx_consts.svh"

module tb_uart_tx;

    localparam int clk_period    = 100;  // ns
    localparam int reset_cycles  = 10;
    localparam int num_rows      = 11;
    localparam int num_fixed     = 5;
    localparam int max_rand_gap  = 4;

    // LOAD, START_BIT, eight DATA_BITS cycles, STOP_BIT
    localparam int busy_cycles   = 1 + 1 + `UART_TX_DATA_BITS + 1;
    // At least one IDLE cycle follows every frame
    localparam int frame_cycles  = busy_cycles + 1;
    // Interfering request window in edges after acceptance
    localparam int intf_on_edge  = 3;
    localparam int intf_off_edge = 6;

    typedef struct packed {
        uart_tx_pkg::tx_byte_t data;
        logic [7:0]            gap;      // Idle cycles before tx_valid
        logic                  intf_en;
        uart_tx_pkg::tx_byte_t intf;     // Put on tx_data while busy
    } row_t;

    typedef struct packed {
        uart_tx_pkg::tx_byte_t data;
        logic                  stop;
        logic [31:0]           start_cycle;
    } frame_t;

    logic                  div_clk;
    logic                  rst_n;
    logic                  tx_valid;
    uart_tx_pkg::tx_byte_t tx_data;
    logic                  tx;
    logic                  tx_ready;
    logic                  tx_busy;

    row_t   rows[num_rows];
    frame_t cap_q[$];      // Frames seen on the serial line
    int     cycle_cnt;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     max_gap;
    int     last_start;
    logic   table_ready;

    uart_tx_top u_dut (
        .div_clk  (div_clk),
        .rst_n    (rst_n),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy)
    );

    initial begin : clock_gen
        div_clk = 1'b0;
        forever #(clk_period / 2) div_clk = ~div_clk;
    end

    always @(posedge div_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("Error at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    // One idle cycle where the line must sit at mark
    task automatic idle_cycle();
        @(posedge div_clk);
        @(negedge div_clk);
        check_value("idle tx", 1'b1, tx);
        check_value("idle tx_ready", 1'b1, tx_ready);
        check_value("idle tx_busy", 1'b0, tx_busy);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (error_count != errs_before) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %0d %s: %s", tests_run, name,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic run_row(input int idx);
        row_t   r;
        frame_t f;
        logic   hold_valid;
        int     accept_cnt;
        int     errs_before;
        int     k;
        r           = rows[idx];
        errs_before = error_count;
        accept_cnt  = 0;
        hold_valid  = 1'b0;
        if (idx + 1 < num_rows) begin
            hold_valid = (rows[idx + 1].gap == 0);  // Next byte goes back-to-back
        end

        if (r.gap != 0) begin
            repeat (r.gap) idle_cycle();
            @(posedge div_clk);
            tx_valid <= 1'b1;
            tx_data  <= r.data;
            @(negedge div_clk);
            check_value("tx_ready before accept", 1'b1, tx_ready);
        end

        // tx_valid and tx_ready are both high so this edge accepts the byte
        @(posedge div_clk);
        tx_valid <= hold_valid;
        for (k = 0; k < busy_cycles; k++) begin
            @(negedge div_clk);
            if (k == 0) begin
                accept_cnt = cycle_cnt;
            end
            check_value("tx_busy in frame", 1'b1, tx_busy);
            check_value("tx_ready in frame", 1'b0, tx_ready);
            @(posedge div_clk);
            if (r.intf_en && (k + 1 == intf_on_edge)) begin
                tx_valid <= 1'b1;
                tx_data  <= r.intf;
            end
            if (r.intf_en && (k + 1 == intf_off_edge)) begin
                tx_valid <= hold_valid;
            end
            if (hold_valid && (k + 1 == busy_cycles)) begin
                tx_data <= rows[idx + 1].data;
            end
        end

        @(negedge div_clk);
        check_value("tx_ready after frame", 1'b1, tx_ready);
        check_value("tx_busy after frame", 1'b0, tx_busy);
        check_value("frames on line", 1, cap_q.size());
        if (cap_q.size() > 0) begin
            f = cap_q.pop_front();
            check_value("frame data", r.data, f.data);
            check_value("stop bit", 1'b1, f.stop);
            check_value("start bit cycle", accept_cnt + 1, f.start_cycle);
            if (r.gap == 0 && idx > 0) begin
                // Stop bit plus the IDLE cycle plus the LOAD cycle stay high
                check_value("high bit times between frames",
                            frame_cycles - 1 - `UART_TX_DATA_BITS,
                            f.start_cycle - last_start - 1 - `UART_TX_DATA_BITS);
            end
            last_start = f.start_cycle;
        end
        finish_test($sformatf("byte %02h gap %0d interferer %0s", r.data, r.gap,
                              r.intf_en ? "on" : "off"), errs_before);
    endtask

    // Assembles each frame from the line LSB first
    initial begin : capture
        frame_t f;
        int     b;
        forever begin
            @(negedge div_clk);
            if (rst_n && tx === 1'b0) begin
                f             = '0;
                f.start_cycle = cycle_cnt;
                for (b = 0; b < `UART_TX_DATA_BITS; b++) begin
                    @(negedge div_clk);
                    f.data[b] = tx;
                end
                @(negedge div_clk);
                f.stop = tx;
                cap_q.push_back(f);
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = longint'(num_rows) * (frame_cycles + max_gap) * clk_period * 2
                   + reset_cycles * clk_period;
        #(limit_ns);
        $display("Run timed out after %0d ns before all frames were checked", limit_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        int i;
        int errs_before;
        rst_n        = 1'b0;
        tx_valid     = 1'b0;
        tx_data      = '0;
        cycle_cnt    = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_start   = 0;
        table_ready  = 1'b0;

        void'($urandom(32'h47c2));
        rows[0] = '{data: 8'h55, gap: 8'd2, intf_en: 1'b0, intf: 8'h00};
        rows[1] = '{data: 8'h00, gap: 8'd0, intf_en: 1'b1, intf: 8'hFF};
        rows[2] = '{data: 8'hFF, gap: 8'd0, intf_en: 1'b1, intf: 8'h00};
        rows[3] = '{data: 8'hA3, gap: 8'd3, intf_en: 1'b1, intf: 8'h5C};
        rows[4] = '{data: 8'h80, gap: 8'd1, intf_en: 1'b0, intf: 8'h00};
        for (i = num_fixed; i < num_rows; i++) begin
            rows[i].data    = $urandom;
            rows[i].gap     = $urandom % (max_rand_gap + 1);
            rows[i].intf_en = $urandom % 2;
            rows[i].intf    = $urandom;
        end
        max_gap = 0;
        for (i = 0; i < num_rows; i++) begin
            if (rows[i].gap > max_gap) begin
                max_gap = rows[i].gap;
            end
        end
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge div_clk);
        rst_n <= 1'b1;

        @(negedge div_clk);
        errs_before = error_count;
        check_value("tx after reset", 1'b1, tx);
        check_value("tx_ready after reset", 1'b1, tx_ready);
        check_value("tx_busy after reset", 1'b0, tx_busy);
        finish_test("reset state", errs_before);

        for (i = 0; i < num_rows; i++) begin
            run_row(i);
        end

        // A quiet line afterwards shows no extra frame was started
        errs_before = error_count;
        repeat (frame_cycles) idle_cycle();
        check_value("extra frames", 0, cap_q.size());
        finish_test("no extra frames", errs_before);

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_tx_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_tx_consts.svh"

module uart_tx_bit_counter (
    input  logic                  div_clk,
    input  logic                  rst_n,
    input  uart_tx_pkg::tx_ctrl_t ctrl,
    output logic                  count_done
);

    localparam logic [`UART_TX_CNT_W-1:0] last_cnt = `UART_TX_DATA_BITS;

    logic [`UART_TX_CNT_W-1:0] count;  // Data bits shifted so far

    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (ctrl.load) begin
            count <= '0;  // New frame
        end else if (ctrl.start_count) begin
            count <= count + 1'b1;
        end
    end

    // Seen by the FSM in the last DATA_BITS cycle
    assign count_done = (count == last_cnt);

    a_count_range: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        count <= last_cnt
    ) else $error("Bit count %0d past frame length", count);

    // FSM must stop counting once the last bit has gone out
    a_no_count_when_done: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        count_done |-> !ctrl.start_count
    ) else $error("Count strobe while count_done is high");

endmodule

`default_nettype wire

// ==== uart_tx_consts.svh ====
`ifndef UART_TX_CONSTS_SVH
`define UART_TX_CONSTS_SVH

// Frame geometry of the byte-wide transmitter
// One div_clk cycle is one bit time on the line

// Data bits per frame, sent LSB first
// The bit counter counts exactly this many shifts per frame
`define UART_TX_DATA_BITS 8

// Bit counter width
// Must hold the value UART_TX_DATA_BITS itself, not just DATA_BITS-1
`define UART_TX_CNT_W 4

`endif

// ==== uart_tx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fsm (
    input  logic                  div_clk,
    input  logic                  rst_n,
    input  logic                  tx_valid,
    input  logic                  count_done,
    output uart_tx_pkg::tx_ctrl_t ctrl,
    output logic                  tx_ready,
    output logic                  tx_busy
);

    uart_tx_pkg::tx_state_t state;
    uart_tx_pkg::tx_state_t next_state;

    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= uart_tx_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Request is sampled straight from tx_valid while idle
    always_comb begin
        next_state = state;
        unique case (state)
            uart_tx_pkg::IDLE: begin
                if (tx_valid) begin
                    next_state = uart_tx_pkg::LOAD;
                end
            end
            uart_tx_pkg::LOAD: begin
                next_state = uart_tx_pkg::START_BIT;
            end
            uart_tx_pkg::START_BIT: begin
                next_state = uart_tx_pkg::DATA_BITS;
            end
            uart_tx_pkg::DATA_BITS: begin
                if (count_done) begin
                    next_state = uart_tx_pkg::STOP_BIT;  // All eight bits are out
                end
            end
            uart_tx_pkg::STOP_BIT: begin
                next_state = uart_tx_pkg::IDLE;
            end
            default: begin
                next_state = uart_tx_pkg::IDLE;
            end
        endcase
    end

    // Mealy outputs
    always_comb begin
        ctrl     = '0;
        tx_ready = 1'b0;
        tx_busy  = 1'b1;
        unique case (state)
            uart_tx_pkg::IDLE: begin
                tx_ready = 1'b1;
                tx_busy  = 1'b0;
            end
            uart_tx_pkg::LOAD: begin
                ctrl.load  = 1'b1;
                ctrl.start = 1'b1;  // Start level goes out on the next edge
            end
            uart_tx_pkg::START_BIT: begin
                // First data bit leaves while the start bit is on the line
                ctrl.start_shift = 1'b1;
                ctrl.start_count = 1'b1;
            end
            uart_tx_pkg::DATA_BITS: begin
                if (!count_done) begin
                    ctrl.start_shift = 1'b1;
                    ctrl.start_count = 1'b1;
                end
            end
            uart_tx_pkg::STOP_BIT: begin
                // Line returns to mark, nothing to strobe
            end
            default: begin
                tx_ready = 1'b1;
                tx_busy  = 1'b0;
            end
        endcase
    end

    a_ready_busy_excl: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        !(tx_ready && tx_busy)
    ) else $error("tx_ready and tx_busy both high");

    a_state_legal: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        state inside {uart_tx_pkg::IDLE, uart_tx_pkg::LOAD, uart_tx_pkg::START_BIT,
                      uart_tx_pkg::DATA_BITS, uart_tx_pkg::STOP_BIT}
    ) else $error("FSM in illegal state %0d", state);

    a_accept_to_load: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        (state == uart_tx_pkg::IDLE && tx_valid) |=> (state == uart_tx_pkg::LOAD)
    ) else $error("Accepted request did not move FSM to LOAD");

endmodule

`default_nettype wire

// ==== uart_tx_line_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_line_driver (
    input  logic                  div_clk,
    input  logic                  rst_n,
    input  uart_tx_pkg::tx_ctrl_t ctrl,
    input  logic                  data_bit,
    output logic                  tx
);

    logic tx_next;

    // Start level over data bit over mark
    always_comb begin
        if (ctrl.start) begin
            tx_next = 1'b0;
        end else if (ctrl.start_shift) begin
            tx_next = data_bit;
        end else begin
            tx_next = 1'b1;  // Idle and stop level
        end
    end

    // Registered so the line never carries decode glitches
    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx <= 1'b1;  // Mark
        end else begin
            tx <= tx_next;
        end
    end

    // Start strobe is one cycle wide, so a low edge on the line
    // is never followed by another start request
    a_single_start: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        $fell(tx) |-> !ctrl.start
    ) else $error("Start strobe held after start bit went out");

endmodule

`default_nettype wire

// ==== uart_tx_pkg.sv ====
`default_nettype none

`include "uart_tx_consts.svh"

package uart_tx_pkg;

    // Frame sequencing states
    typedef enum logic [2:0] {
        IDLE      = 3'b000,  // Line at mark and ready for a byte
        LOAD      = 3'b001,  // Byte captured and start level registered
        START_BIT = 3'b010,
        DATA_BITS = 3'b011,  // Eight bit times and the last waits on count_done
        STOP_BIT  = 3'b100
    } tx_state_t;

    // Strobes from the FSM to the datapath blocks
    // All four are levels decoded from the state
    typedef struct packed {
        logic load;         // Capture byte and clear counter
        logic start_shift;  // Shift data and drive data bit onto line
        logic start_count;  // Count one data bit
        logic start;        // Drive start level onto line
    } tx_ctrl_t;

    // Payload byte
    typedef logic [`UART_TX_DATA_BITS-1:0] tx_byte_t;

endpackage

`default_nettype wire

// ==== uart_tx_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shifter (
    input  logic                  div_clk,
    input  logic                  rst_n,
    input  uart_tx_pkg::tx_ctrl_t ctrl,
    input  uart_tx_pkg::tx_byte_t tx_data,
    output logic                  data_bit
);

    uart_tx_pkg::tx_byte_t shreg;  // Frame byte, LSB is the next bit out
    uart_tx_pkg::tx_byte_t shreg_next;

    // Load wins by construction, the FSM never raises both
    always_comb begin
        shreg_next = shreg;
        if (ctrl.load) begin
            shreg_next = tx_data;
        end else if (ctrl.start_shift) begin
            shreg_next = shreg >> 1;  // Zero fill from the top
        end
    end

    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            shreg <= '0;
        end else begin
            shreg <= shreg_next;
        end
    end

    assign data_bit = shreg[0];

    // Load and shift come from different states
    a_load_shift_excl: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        !(ctrl.load && ctrl.start_shift)
    ) else $error("Shifter got load and shift together");

endmodule

`default_nettype wire

// ==== uart_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_top (
    input  logic                  div_clk,
    input  logic                  rst_n,
    input  logic                  tx_valid,
    input  uart_tx_pkg::tx_byte_t tx_data,
    output logic                  tx,
    output logic                  tx_ready,
    output logic                  tx_busy
);

    uart_tx_pkg::tx_ctrl_t ctrl;
    logic                  count_done;
    logic                  data_bit;

    uart_tx_fsm u_fsm (
        .div_clk    (div_clk),
        .rst_n      (rst_n),
        .tx_valid   (tx_valid),
        .count_done (count_done),
        .ctrl       (ctrl),
        .tx_ready   (tx_ready),
        .tx_busy    (tx_busy)
    );

    uart_tx_shifter u_shifter (
        .div_clk  (div_clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .tx_data  (tx_data),
        .data_bit (data_bit)
    );

    uart_tx_bit_counter u_bit_counter (
        .div_clk    (div_clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .count_done (count_done)
    );

    uart_tx_line_driver u_line_driver (
        .div_clk  (div_clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .data_bit (data_bit),
        .tx       (tx)
    );

    // Line driver lags the FSM by one edge
    a_start_on_line: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        (u_fsm.state == uart_tx_pkg::START_BIT) |-> !tx
    ) else $error("Line not low during START_BIT");

    a_stop_on_line: assert property (
        @(posedge div_clk) disable iff (!rst_n)
        (u_fsm.state == uart_tx_pkg::STOP_BIT) |-> tx
    ) else $error("Line not high during STOP_BIT");

endmodule

`default_nettype wire
